// ==== rtl/rs_types_pkg.sv ====
`default_nettype none

package rs_types_pkg;

    // Operand and result value
    typedef logic [15:0] data_t;

    // Result tag, 0 means no pending producer
    typedef logic [3:0] tag_t;

    // Architectural register index
    typedef logic [2:0] reg_idx_t;

    // Functional-unit class of an instruction
    typedef enum logic {
        CLASS_ALU = 1'b0,
        CLASS_MUL = 1'b1
    } fu_class_t;

    // ALU result slot
    typedef enum logic {
        ALU_IDLE = 1'b0,  // Slot empty
        ALU_HOLD = 1'b1   // Slot holds a result for the CDB
    } alu_state_t;

    localparam int NUM_REGS = 8;
    localparam int NUM_TAGS = 16;

    localparam tag_t TAG_NONE  = 4'd0;
    localparam tag_t TAG_FIRST = 4'd1;
    localparam tag_t TAG_LAST  = 4'd15;  // Counter wraps back to TAG_FIRST

endpackage

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    import rs_types_pkg::*;

    // Operations, 3-bit encoding
    typedef enum logic [2:0] {
        ADD  = 3'd0,  // rs1 + rs2
        SUB  = 3'd1,  // rs1 - rs2
        AND  = 3'd2,  // rs1 & rs2
        XOR  = 3'd3,  // rs1 ^ rs2
        ADDI = 3'd4,  // rs1 + imm
        MUL  = 3'd5   // Low 16 bits of rs1 * rs2
    } op_t;

    // Functional-unit class that executes an operation
    function automatic fu_class_t op_class(input op_t op);
        fu_class_t cls;
        if (op == MUL) begin
            cls = CLASS_MUL;
        end else begin
            cls = CLASS_ALU;
        end
        return cls;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/rename_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_table
    import rs_types_pkg::*;
    import isa_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  op_t      dispatch_op,
    input  reg_idx_t dispatch_rd,
    input  reg_idx_t dispatch_rs1,
    input  reg_idx_t dispatch_rs2,
    input  data_t    dispatch_imm,
    input  logic     alu_slot_free,
    input  logic     mul_slot_free,
    input  logic     cdb_valid,
    input  tag_t     cdb_tag,
    input  data_t    cdb_value,
    output logic     dispatch_ready,
    output tag_t     dispatch_tag,
    output logic     alloc,
    output op_t      alloc_op,
    output tag_t     alloc_tag,
    output data_t    alloc_imm,
    output data_t    src1_value,
    output data_t    src2_value,
    output tag_t     src1_tag,
    output tag_t     src2_tag
);

    logic                started;  // Low for the first cycle after reset
    data_t               map_value [NUM_REGS];
    tag_t                map_tag   [NUM_REGS];
    logic [NUM_TAGS-1:0] tag_busy;
    tag_t                next_tag;
    logic                class_free;
    tag_t                src1_pend;
    tag_t                src2_pend;
    logic                src1_hit;
    logic                src2_hit;

    assign class_free = (op_class(dispatch_op) == CLASS_MUL) ? mul_slot_free : alu_slot_free;

    // Stall on a busy next tag, never skip it
    assign dispatch_ready = started && !tag_busy[next_tag] && class_free;
    assign dispatch_tag   = next_tag;

    assign alloc     = dispatch_valid && dispatch_ready;
    assign alloc_op  = dispatch_op;
    assign alloc_tag = next_tag;
    assign alloc_imm = dispatch_imm;

    // Register 0 keeps tag 0 and value 0 forever
    assign src1_pend = map_tag[dispatch_rs1];
    assign src2_pend = map_tag[dispatch_rs2];

    // Same-cycle CDB bypass
    assign src1_hit = cdb_valid && (src1_pend == cdb_tag);
    assign src2_hit = cdb_valid && (src2_pend == cdb_tag);

    assign src1_tag   = src1_hit ? TAG_NONE : src1_pend;
    assign src2_tag   = src2_hit ? TAG_NONE : src2_pend;
    assign src1_value = src1_hit ? cdb_value : map_value[dispatch_rs1];
    assign src2_value = src2_hit ? cdb_value : map_value[dispatch_rs2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            started  <= 1'b0;
            next_tag <= TAG_FIRST;
            tag_busy <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                map_value[r] <= '0;
                map_tag[r]   <= TAG_NONE;
            end
        end else begin
            started <= 1'b1;
            if (cdb_valid) begin
                tag_busy[cdb_tag] <= 1'b0;  // Tag reusable from the next cycle
                for (int r = 1; r < NUM_REGS; r++) begin
                    if (map_tag[r] == cdb_tag) begin
                        map_value[r] <= cdb_value;
                        map_tag[r]   <= TAG_NONE;
                    end
                end
            end
            if (alloc) begin
                tag_busy[next_tag] <= 1'b1;
                next_tag <= (next_tag == TAG_LAST) ? TAG_FIRST : next_tag + 1'b1;
                // Newer producer wins over a broadcast to the same register
                if (dispatch_rd != '0) begin
                    map_tag[dispatch_rd] <= next_tag;
                end
            end
        end
    end

    // Only tags handed out at dispatch may come back on the CDB
    a_cdb_tag_busy: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> tag_busy[cdb_tag]
    );

endmodule

`default_nettype wire

// ==== rtl/reservation_station.sv ====
`timescale 1ns/100ps
`default_nettype none

module reservation_station
    import rs_types_pkg::*;
    import isa_pkg::*;
#(
    parameter int ALU_ENTRIES = 4,
    parameter int MUL_ENTRIES = 2
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  alloc,
    input  op_t   alloc_op,
    input  tag_t  alloc_tag,
    input  data_t alloc_imm,
    input  data_t src1_value,
    input  data_t src2_value,
    input  tag_t  src1_tag,
    input  tag_t  src2_tag,
    input  logic  cdb_valid,
    input  tag_t  cdb_tag,
    input  data_t cdb_value,
    input  logic  alu_accept,
    output logic  alu_slot_free,
    output logic  mul_slot_free,
    output logic  alu_issue,
    output op_t   alu_issue_op,
    output data_t alu_issue_a,
    output data_t alu_issue_b,
    output tag_t  alu_issue_tag,
    output logic  mul_issue,
    output data_t mul_issue_a,
    output data_t mul_issue_b,
    output tag_t  mul_issue_tag
);

    localparam int N     = ALU_ENTRIES + MUL_ENTRIES;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    // ALU entries sit at the low indices, MUL entries above them
    localparam logic [N-1:0] MUL_MASK = {{MUL_ENTRIES{1'b1}}, {ALU_ENTRIES{1'b0}}};
    localparam logic [N-1:0] ALU_MASK = ~MUL_MASK;

    logic [N-1:0]     entry_valid;
    op_t              entry_op    [N];
    tag_t             entry_tag   [N];  // Result tag of the entry
    data_t            entry_a     [N];
    tag_t             entry_a_tag [N];
    data_t            entry_b     [N];
    tag_t             entry_b_tag [N];

    logic [N-1:0]     entry_ready;
    logic [N-1:0]     alloc_mask;
    logic [N-1:0]     alu_ready_mask;
    logic [N-1:0]     mul_ready_mask;
    logic             alloc_found;
    logic             alu_found;
    logic             mul_found;
    logic [IDX_W-1:0] alloc_sel;
    logic [IDX_W-1:0] alu_sel;
    logic [IDX_W-1:0] mul_sel;

    // Index of the lowest set bit
    function automatic logic [IDX_W-1:0] lowest(input logic [N-1:0] mask);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < N; i++) begin
            entry_ready[i] = entry_valid[i] && (entry_a_tag[i] == TAG_NONE)
                             && (entry_b_tag[i] == TAG_NONE);
        end
    end

    assign alu_slot_free = |(~entry_valid & ALU_MASK);
    assign mul_slot_free = |(~entry_valid & MUL_MASK);

    // Allocation into the lowest free entry of the class
    assign alloc_mask  = ~entry_valid
                         & ((op_class(alloc_op) == CLASS_MUL) ? MUL_MASK : ALU_MASK);
    assign alloc_found = |alloc_mask;
    assign alloc_sel   = lowest(alloc_mask);

    // Issue select per class
    assign alu_ready_mask = entry_ready & ALU_MASK;
    assign mul_ready_mask = entry_ready & MUL_MASK;
    assign alu_found      = |alu_ready_mask;
    assign mul_found      = |mul_ready_mask;
    assign alu_sel        = lowest(alu_ready_mask);
    assign mul_sel        = lowest(mul_ready_mask);

    assign alu_issue     = alu_found && alu_accept;  // Held back while ALU result is blocked
    assign alu_issue_op  = entry_op[alu_sel];
    assign alu_issue_a   = entry_a[alu_sel];
    assign alu_issue_b   = entry_b[alu_sel];
    assign alu_issue_tag = entry_tag[alu_sel];

    assign mul_issue     = mul_found;  // Multiplier never stalls
    assign mul_issue_a   = entry_a[mul_sel];
    assign mul_issue_b   = entry_b[mul_sel];
    assign mul_issue_tag = entry_tag[mul_sel];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            if (alu_issue) begin
                entry_valid[alu_sel] <= 1'b0;
            end
            if (mul_issue) begin
                entry_valid[mul_sel] <= 1'b0;
            end
            if (alloc) begin
                entry_valid[alloc_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        // CDB wake-up
        for (int i = 0; i < N; i++) begin
            if (cdb_valid && entry_valid[i] && (entry_a_tag[i] == cdb_tag)) begin
                entry_a[i]     <= cdb_value;
                entry_a_tag[i] <= TAG_NONE;
            end
            if (cdb_valid && entry_valid[i] && (entry_b_tag[i] == cdb_tag)) begin
                entry_b[i]     <= cdb_value;
                entry_b_tag[i] <= TAG_NONE;
            end
        end
        if (alloc) begin
            entry_op[alloc_sel]    <= alloc_op;
            entry_tag[alloc_sel]   <= alloc_tag;
            entry_a[alloc_sel]     <= src1_value;
            entry_a_tag[alloc_sel] <= src1_tag;
            if (alloc_op == ADDI) begin
                entry_b[alloc_sel]     <= alloc_imm;  // Immediate is always ready
                entry_b_tag[alloc_sel] <= TAG_NONE;
            end else begin
                entry_b[alloc_sel]     <= src2_value;
                entry_b_tag[alloc_sel] <= src2_tag;
            end
        end
    end

    // Dispatch side must only allocate when a slot of the class is free
    a_alloc_free: assert property (
        @(posedge clock) disable iff (reset)
        alloc |-> alloc_found
    );

endmodule

`default_nettype wire

// ==== rtl/exec_units.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_units
    import rs_types_pkg::*;
    import isa_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  alu_issue,
    input  op_t   alu_issue_op,
    input  data_t alu_issue_a,
    input  data_t alu_issue_b,
    input  tag_t  alu_issue_tag,
    input  logic  mul_issue,
    input  data_t mul_issue_a,
    input  data_t mul_issue_b,
    input  tag_t  mul_issue_tag,
    output logic  alu_accept,
    output logic  cdb_valid,
    output tag_t  cdb_tag,
    output data_t cdb_value
);

    alu_state_t alu_state;
    tag_t       alu_tag_q;
    data_t      alu_value_q;
    data_t      alu_result;
    logic       alu_grant;

    // Multiplier stage 1 holds operands, stage 2 the product
    logic       mul1_valid;
    tag_t       mul1_tag;
    data_t      mul1_a;
    data_t      mul1_b;
    data_t      mul_product;
    logic       mul2_valid;
    tag_t       mul2_tag;
    data_t      mul2_value;

    always_comb begin
        case (alu_issue_op)
            ADD, ADDI: alu_result = alu_issue_a + alu_issue_b;
            SUB:       alu_result = alu_issue_a - alu_issue_b;
            AND:       alu_result = alu_issue_a & alu_issue_b;
            XOR:       alu_result = alu_issue_a ^ alu_issue_b;
            default:   alu_result = '0;  // MUL is never issued here
        endcase
    end

    // Multiplier owns the CDB whenever stage 2 is full
    assign alu_grant  = (alu_state == ALU_HOLD) && !mul2_valid;
    assign alu_accept = (alu_state == ALU_IDLE) || alu_grant;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_state <= ALU_IDLE;
        end else begin
            case (alu_state)
                ALU_IDLE: begin
                    if (alu_issue) begin
                        alu_state <= ALU_HOLD;
                    end
                end
                ALU_HOLD: begin
                    // A new issue refills the slot in the cycle it drains
                    if (alu_grant && !alu_issue) begin
                        alu_state <= ALU_IDLE;
                    end
                end
                default: alu_state <= ALU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue) begin
            alu_tag_q   <= alu_issue_tag;
            alu_value_q <= alu_result;
        end
    end

    assign mul_product = mul1_a * mul1_b;  // Low 16 bits kept

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mul1_valid <= 1'b0;
            mul2_valid <= 1'b0;
        end else begin
            mul1_valid <= mul_issue;
            mul2_valid <= mul1_valid;
        end
    end

    always_ff @(posedge clock) begin
        mul1_tag   <= mul_issue_tag;
        mul1_a     <= mul_issue_a;
        mul1_b     <= mul_issue_b;
        mul2_tag   <= mul1_tag;
        mul2_value <= mul_product;
    end

    // CDB arbitration
    assign cdb_valid = mul2_valid || (alu_state == ALU_HOLD);
    assign cdb_tag   = mul2_valid ? mul2_tag : alu_tag_q;
    assign cdb_value = mul2_valid ? mul2_value : alu_value_q;

    // Tag 0 is never handed out at dispatch
    a_cdb_tag_nonzero: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_tag != TAG_NONE
    );

endmodule

`default_nettype wire

// ==== rtl/rs_cluster.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_cluster
    import rs_types_pkg::*;
    import isa_pkg::*;
#(
    parameter int ALU_ENTRIES = 4,
    parameter int MUL_ENTRIES = 2
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  op_t      dispatch_op,
    input  reg_idx_t dispatch_rd,
    input  reg_idx_t dispatch_rs1,
    input  reg_idx_t dispatch_rs2,
    input  data_t    dispatch_imm,
    output logic     dispatch_ready,
    output tag_t     dispatch_tag,
    output logic     cdb_valid,
    output tag_t     cdb_tag,
    output data_t    cdb_value
);

    // Rename table to reservation station
    logic  alloc;
    op_t   alloc_op;
    tag_t  alloc_tag;
    data_t alloc_imm;
    data_t src1_value;
    data_t src2_value;
    tag_t  src1_tag;
    tag_t  src2_tag;
    logic  alu_slot_free;
    logic  mul_slot_free;

    // Reservation station to execution units
    logic  alu_issue;
    op_t   alu_issue_op;
    data_t alu_issue_a;
    data_t alu_issue_b;
    tag_t  alu_issue_tag;
    logic  mul_issue;
    data_t mul_issue_a;
    data_t mul_issue_b;
    tag_t  mul_issue_tag;
    logic  alu_accept;

    rename_table u_rename_table (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .alu_slot_free  (alu_slot_free),
        .mul_slot_free  (mul_slot_free),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .alloc          (alloc),
        .alloc_op       (alloc_op),
        .alloc_tag      (alloc_tag),
        .alloc_imm      (alloc_imm),
        .src1_value     (src1_value),
        .src2_value     (src2_value),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag)
    );

    reservation_station #(
        .ALU_ENTRIES (ALU_ENTRIES),
        .MUL_ENTRIES (MUL_ENTRIES)
    ) u_reservation_station (
        .clock         (clock),
        .reset         (reset),
        .alloc         (alloc),
        .alloc_op      (alloc_op),
        .alloc_tag     (alloc_tag),
        .alloc_imm     (alloc_imm),
        .src1_value    (src1_value),
        .src2_value    (src2_value),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .alu_accept    (alu_accept),
        .alu_slot_free (alu_slot_free),
        .mul_slot_free (mul_slot_free),
        .alu_issue     (alu_issue),
        .alu_issue_op  (alu_issue_op),
        .alu_issue_a   (alu_issue_a),
        .alu_issue_b   (alu_issue_b),
        .alu_issue_tag (alu_issue_tag),
        .mul_issue     (mul_issue),
        .mul_issue_a   (mul_issue_a),
        .mul_issue_b   (mul_issue_b),
        .mul_issue_tag (mul_issue_tag)
    );

    exec_units u_exec_units (
        .clock         (clock),
        .reset         (reset),
        .alu_issue     (alu_issue),
        .alu_issue_op  (alu_issue_op),
        .alu_issue_a   (alu_issue_a),
        .alu_issue_b   (alu_issue_b),
        .alu_issue_tag (alu_issue_tag),
        .mul_issue     (mul_issue),
        .mul_issue_a   (mul_issue_a),
        .mul_issue_b   (mul_issue_b),
        .mul_issue_tag (mul_issue_tag),
        .alu_accept    (alu_accept),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value)
    );

endmodule

`default_nettype wire

// ==== dv/rs_cluster_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_cluster_tb
    import rs_types_pkg::*;
    import isa_pkg::*;
();

    localparam int CLOCK_HALF   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;

    logic     clock;
    logic     reset;
    logic     dispatch_valid;
    op_t      dispatch_op;
    reg_idx_t dispatch_rd;
    reg_idx_t dispatch_rs1;
    reg_idx_t dispatch_rs2;
    data_t    dispatch_imm;
    logic     dispatch_ready;
    tag_t     dispatch_tag;
    logic     cdb_valid;
    tag_t     cdb_tag;
    data_t    cdb_value;

    // Instruction stream from the stimulus file
    op_t      stim_op     [$];
    reg_idx_t stim_rd     [$];
    reg_idx_t stim_rs1    [$];
    reg_idx_t stim_rs2    [$];
    data_t    stim_imm    [$];
    data_t    stim_expect [$];
    int       stim_gap    [$];
    logic     stim_loaded;

    // Scoreboard, one slot per tag
    logic [NUM_TAGS-1:0] tag_pending;
    data_t               expect_by_tag [NUM_TAGS];
    int                  instr_by_tag  [NUM_TAGS];
    int                  broadcast_count;
    int                  stall_cycles;  // Cycles where a dispatch waited on dispatch_ready

    rs_cluster #(
        .ALU_ENTRIES (4),
        .MUL_ENTRIES (2)
    ) dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    initial clock = 1'b0;
    always #(CLOCK_HALF) clock = ~clock;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected %0d actual %0d",
                                    name, expected, actual));
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_rd;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [31:0] f_imm;
        logic [31:0] f_exp;
        logic [31:0] f_gap;
        fd = $fopen("dv/rs_stimulus.txt", "r");
        if (fd == 0) begin
            stop_on_error("Cannot open the stimulus file dv/rs_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;  // Column description
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_rd, f_rs1, f_rs2, f_imm, f_exp, f_gap);
            if (n <= 0) begin
                continue;
            end
            if (n != 7) begin
                stop_on_error($sformatf("Stimulus line has %0d fields instead of 7: %s", n, line));
            end
            stim_op.push_back(op_t'(f_op[2:0]));
            stim_rd.push_back(f_rd[2:0]);
            stim_rs1.push_back(f_rs1[2:0]);
            stim_rs2.push_back(f_rs2[2:0]);
            stim_imm.push_back(f_imm[15:0]);
            stim_expect.push_back(f_exp[15:0]);
            stim_gap.push_back(int'(f_gap));
        end
        $fclose(fd);
        if (stim_op.size() == 0) begin
            stop_on_error("The stimulus file holds no instructions");
        end
    endtask

    // Called at the sampling point of an accepting cycle
    task automatic record_dispatch(input int idx, input tag_t expected_tag);
        check_tag($sformatf("dispatch tag of instr %0d", idx), expected_tag, dispatch_tag);
        if (tag_pending[expected_tag]) begin
            stop_on_error($sformatf("Tag %0d handed out again before its result came back",
                                    expected_tag));
        end
        tag_pending[expected_tag]   = 1'b1;
        expect_by_tag[expected_tag] = stim_expect[idx];
        instr_by_tag[expected_tag]  = idx;
    endtask

    // CDB monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (reset === 1'b1) begin
            if (cdb_valid !== 1'b0) begin
                stop_on_error("cdb_valid is not low during reset");
            end
        end else if (cdb_valid !== 1'b0) begin
            if (cdb_valid !== 1'b1) begin
                stop_on_error("cdb_valid is unknown after reset");
            end
            if (!tag_pending[cdb_tag]) begin
                stop_on_error($sformatf("Tag %0d broadcast with no instruction waiting on it",
                                        cdb_tag));
            end
            check_value($sformatf("instr %0d result on tag %0d", instr_by_tag[cdb_tag], cdb_tag),
                        expect_by_tag[cdb_tag], cdb_value);
            tag_pending[cdb_tag] = 1'b0;
            broadcast_count++;
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_loaded === 1'b1);
        limit = stim_op.size() * 20 + 200;  // Cycles
        repeat (limit) @(posedge clock);
        stop_on_error($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                                limit, broadcast_count, stim_op.size()));
    end

    initial begin : main
        tag_t expected_tag;
        logic accepted;
        reset           = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch_op     = ADD;
        dispatch_rd     = '0;
        dispatch_rs1    = '0;
        dispatch_rs2    = '0;
        dispatch_imm    = '0;
        tag_pending     = '0;
        broadcast_count = 0;
        stall_cycles    = 0;
        stim_loaded     = 1'b0;
        read_stimulus();
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b0;

        @(negedge clock);
        if (dispatch_ready !== 1'b0) begin
            stop_on_error("dispatch_ready is high in the first cycle after reset");
        end
        @(posedge clock);
        #(DRIVE_DELAY);

        expected_tag = 4'd1;  // Tags run 1 to 15, then wrap
        for (int i = 0; i < stim_op.size(); i++) begin
            dispatch_valid = 1'b1;
            dispatch_op    = stim_op[i];
            dispatch_rd    = stim_rd[i];
            dispatch_rs1   = stim_rs1[i];
            dispatch_rs2   = stim_rs2[i];
            dispatch_imm   = stim_imm[i];
            accepted       = 1'b0;
            while (!accepted) begin
                @(negedge clock);
                if (dispatch_ready === 1'b1) begin
                    accepted = 1'b1;
                    record_dispatch(i, expected_tag);
                    expected_tag = (expected_tag == 4'd15) ? 4'd1 : expected_tag + 4'd1;
                end else begin
                    stall_cycles++;
                end
                @(posedge clock);
                #(DRIVE_DELAY);
            end
            dispatch_valid = 1'b0;
            repeat (stim_gap[i]) begin
                @(posedge clock);
                #(DRIVE_DELAY);
            end
        end

        while (broadcast_count < stim_op.size()) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);  // Late or repeated broadcasts would show here

        if (stall_cycles == 0) begin
            stop_on_error("dispatch_ready never dropped while an instruction was waiting");
        end
        // Every tag and entry is free again once all results are back
        if (dispatch_ready === 1'b1) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stop_on_error("dispatch_ready is still low after every result came back");
        end
    end

endmodule

`default_nettype wire

// ==== rs_cluster.f ====
rtl/rs_types_pkg.sv
rtl/isa_pkg.sv
rtl/rename_table.sv
rtl/reservation_station.sv
rtl/exec_units.sv
rtl/rs_cluster.sv
dv/rs_cluster_tb.sv

// ==== dv/rs_stimulus.txt ====
# op rd rs1 rs2 imm expected gap, all hex, gap is idle cycles after the instruction
# op 0 ADD, 1 SUB, 2 AND, 3 XOR, 4 ADDI, 5 MUL, register 0 reads zero
4 1 0 0 1234 1234 0
4 2 0 0 0f0f 0f0f 6
0 3 1 2 0000 2143 0
1 4 1 2 0000 0325 0
2 5 1 2 0000 0204 0
3 6 1 2 0000 1d3b 6
4 7 3 0 0001 2144 1
0 7 7 7 0000 4288 1
1 1 7 4 0000 3f63 0
3 2 1 7 0000 7deb 6
5 3 5 6 0000 eaec 0
5 4 1 2 0000 86e1 0
0 5 3 4 0000 71cd 0
4 6 2 0 0100 7eeb 0
5 7 5 5 0000 9e29 0
3 1 6 7 0000 e0c2 0
5 2 7 1 0000 bb12 0
4 3 2 0 0001 bb13 0
0 4 2 2 0000 7624 0
1 5 2 0 0000 bb12 0
2 6 2 3 0000 bb12 0
3 7 2 4 0000 cd36 0
0 1 7 6 0000 8848 0
4 0 1 0 5555 dd9d 0
0 3 0 1 0000 8848 0
